// ==== bench/ipic_sva.sv ====
//------------------------------
// Bound into the service block and sees its internal state directly
//------------------------------
`include "ipic_config.svh"

module ipic_sva (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`IPIC_VECT_W-1:0]     cisv_i,
    input  logic [`IPIC_LINES_NUM-1:0]  isvr_i,
    input  logic [`IPIC_LINES_NUM-1:0]  req_v_i,    // Pending and enabled
    input  logic [`IPIC_IDX_W:0]        start_i,    // Valid flag over line index
    input  logic                        irq_req_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Void vector and empty ISVR go together
    cisv_void_a: assert property (@(posedge clk) disable iff (!rst_n)
        (cisv_i == `IPIC_VOID_VECT) == (isvr_i == '0))
        else $error("CISV and ISVR disagree on service state");

    // Start needs a live request and takes the best pending line
    start_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        start_i[`IPIC_IDX_W] |-> irq_req_i && req_v_i[start_i[`IPIC_IDX_W-1:0]]
            && ((req_v_i & ((16'd1 << start_i[`IPIC_IDX_W-1:0]) - 16'd1)) == '0))
        else $error("Start pulse without a matching request");

    // Quiet right after reset
    reset_req_a: assert property (@(posedge clk)
        $rose(rst_n) |-> !irq_req_i)
        else $error("Request set in first cycle after reset");

endmodule

bind ipic_service_ctrl ipic_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .cisv_i     (cisv_q),
    .isvr_i     (isvr_q),
    .req_v_i    (req_v),
    .start_i    (start_o),
    .irq_req_i  (irq_m_req_o)
);

// ==== bench/ipic_tb.sv ====
//------------------------------
// Mirror assumes lines settle within four cycles of a change
//------------------------------
`include "ipic_config.svh"

module ipic_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ipic_pkg::*;

    logic clk;
    logic rst_n;
    ipic_vec_t irq_lines;
    ipic_csr_req_t csr_req;
    logic [31:0] rdata;
    logic irq_req;

    // Mirror of controller state
    ipic_vec_t m_ier, m_imr, m_inv, m_ipr, m_isvr;
    logic [4:0] m_cisv;
    logic [3:0] m_idx;
    logic [31:0] exp_rd;        // Expected read data
    string rd_name;
    int errors;
    int checks;
    int unsigned seed;

    ipic_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .csr_req_i   (csr_req),
        .rdata_o     (rdata),
        .irq_m_req_o (irq_req)
    );

    always #50 clk = ~clk;      // 100 ns period

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    // Lowest set bit, 16 when none
    function automatic logic [4:0] lowest_set(input ipic_vec_t v);
        logic [4:0] r;
        r = 5'd16;
        for (int i = 15; i >= 0; i--) if (v[i]) r = 5'(i);
        return r;
    endfunction

    function automatic logic ref_req();
        logic [4:0] n;
        n = lowest_set(m_ipr & m_ier);
        return (n != 5'd16) && ((m_cisv == 5'd16) || (n < m_cisv));
    endfunction

    // Expected read data by address
    function automatic logic [31:0] ref_read(input logic [2:0] addr);
        logic [31:0] r;
        r = '0;
        case (addr)
            `IPIC_ADDR_CISV : r = 32'(m_cisv);
            `IPIC_ADDR_IPR  : r = 32'(m_ipr);
            `IPIC_ADDR_ISVR : r = 32'(m_isvr);
            `IPIC_ADDR_IDX  : r = 32'(m_idx);
            `IPIC_ADDR_ICSR : begin
                r[0] = m_ipr[m_idx];
                r[1] = m_ier[m_idx];
                r[2] = m_imr[m_idx];
                r[3] = m_inv[m_idx];
                r[4] = m_isvr[m_idx];
                r[9:8] = 2'd3;                  // Machine mode
                r[19:16] = m_idx;
            end
            default : r = '0;
        endcase
        return r;
    endfunction

    // Level mode pending tracks the active level
    function automatic void follow_levels();
        ipic_vec_t lvl;
        lvl = irq_lines ^ m_inv;
        m_ipr = (m_ipr & m_imr) | (lvl & ~m_imr);
    endfunction

    // Effect of one write on the mirror
    function automatic void apply_write(input logic [2:0] addr, input logic [31:0] data);
        ipic_vec_t lvl;
        logic [4:0] n;
        lvl = irq_lines ^ m_inv;
        case (addr)
            `IPIC_ADDR_IDX : m_idx = data[3:0];
            `IPIC_ADDR_ICSR : begin
                if (data[0] && (m_imr[m_idx] || !lvl[m_idx])) m_ipr[m_idx] = 1'b0;
                m_ier[m_idx] = data[1];
                m_imr[m_idx] = data[2];
                m_inv[m_idx] = data[3];
            end
            `IPIC_ADDR_IPR : m_ipr = m_ipr & ~(data[15:0] & (m_imr | ~lvl));
            `IPIC_ADDR_SOI : if (ref_req()) begin
                n = lowest_set(m_ipr & m_ier);
                m_isvr[n[3:0]] = 1'b1;
                m_cisv = n;
                if (m_imr[n[3:0]] || !lvl[n[3:0]]) m_ipr[n[3:0]] = 1'b0;
            end
            `IPIC_ADDR_EOI : if (m_cisv != 5'd16) begin
                m_isvr[m_cisv[3:0]] = 1'b0;
                m_cisv = lowest_set(m_isvr);    // 16 once empty
            end
            default : ;
        endcase
        follow_levels();
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Comparator ---------------------
    always @(posedge clk) begin
        if (csr_req.rd) check_value(rd_name, exp_rd, rdata);
    end

    task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
        @(negedge clk);
        csr_req.wr = 1'b1;
        csr_req.addr = addr;
        csr_req.wdata = data;
        apply_write(addr, data);
        @(negedge clk);
        csr_req = '0;
    endtask

    task automatic csr_read(input logic [2:0] addr, input string name);
        @(negedge clk);
        csr_req.rd = 1'b1;
        csr_req.addr = addr;
        exp_rd = ref_read(addr);
        rd_name = name;
        @(negedge clk);
        csr_req = '0;
    endtask

    // Line change, then the fixed three edge latency plus margin
    task automatic set_line(input int n, input logic val);
        logic old_lvl;
        @(negedge clk);
        old_lvl = irq_lines[n] ^ m_inv[n];
        irq_lines[n] = val;
        if (m_imr[n] && (val ^ m_inv[n]) && !old_lvl) m_ipr[n] = 1'b1;
        follow_levels();
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_req(input logic exp);
        int cnt;
        cnt = 0;
        while (irq_req !== exp && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (irq_req !== exp) begin
            errors++;
            $display("Timed out at %0d ns waiting for the request to become %b", $time, exp);
        end
    endtask

    task automatic write_icsr(input int n, input logic [31:0] data);
        csr_write(`IPIC_ADDR_IDX, 32'(n));
        csr_write(`IPIC_ADDR_ICSR, data);
    endtask

    initial begin
        int n;
        logic p;
        clk = 1'b0;
        rst_n = 1'b0;
        irq_lines = '0;
        csr_req = '0;
        {m_ier, m_imr, m_inv, m_ipr, m_isvr} = '0;
        m_cisv = 5'd16;
        m_idx = '0;
        exp_rd = '0;
        rd_name = "";
        errors = 0;
        checks = 0;
        seed = 51;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values -------------------
        check_value("irq_m_req_o", 0, 32'(irq_req));
        csr_read(`IPIC_ADDR_CISV, "CISV");
        csr_read(`IPIC_ADDR_IPR, "IPR");
        csr_read(`IPIC_ADDR_ISVR, "ISVR");
        csr_read(`IPIC_ADDR_IDX, "IDX");

        // Random ICSR writes, IP left 0
        for (int i = 0; i < 12; i++) begin
            n = int'(lcg_next() % 16);
            write_icsr(n, {28'd0, 3'(lcg_next() % 8), 1'b0});
            csr_read(`IPIC_ADDR_ICSR, "ICSR");
            csr_read(`IPIC_ADDR_IPR, "IPR");
        end
        for (int i = 0; i < 16; i++) write_icsr(i, 32'd0);     // Clean slate
        csr_read(`IPIC_ADDR_IPR, "IPR");

        // Level mode with polarity -------
        for (int i = 0; i < 4; i++) begin
            n = 4 + int'(lcg_next() % 12);
            p = 1'(lcg_next() % 2);
            set_line(n, p);                                     // Inactive level
            write_icsr(n, 32'h2 | (32'(p) << 3));
            set_line(n, !p);
            wait_req(1'b1);
            csr_read(`IPIC_ADDR_IPR, "IPR");
            csr_read(`IPIC_ADDR_ICSR, "ICSR");
            set_line(n, p);
            wait_req(1'b0);
            csr_read(`IPIC_ADDR_IPR, "IPR");
            write_icsr(n, 32'd0);
            set_line(n, 1'b0);
        end

        // Edge mode
        write_icsr(5, 32'h6);
        set_line(5, 1'b1);
        wait_req(1'b1);
        set_line(5, 1'b0);
        csr_read(`IPIC_ADDR_IPR, "IPR");
        csr_write(`IPIC_ADDR_IPR, 32'h20);
        csr_read(`IPIC_ADDR_IPR, "IPR");
        wait_req(1'b0);
        set_line(5, 1'b1);
        set_line(5, 1'b0);
        wait_req(1'b1);
        csr_write(`IPIC_ADDR_ICSR, 32'h7);                      // IP set clears
        csr_read(`IPIC_ADDR_ICSR, "ICSR");
        wait_req(1'b0);

        // Priority and nesting -----------
        write_icsr(3, 32'h6);
        write_icsr(7, 32'h6);
        write_icsr(10, 32'h6);
        set_line(7, 1'b1);
        set_line(10, 1'b1);
        set_line(7, 1'b0);
        set_line(10, 1'b0);
        wait_req(1'b1);
        csr_write(`IPIC_ADDR_SOI, 32'd0);
        csr_read(`IPIC_ADDR_CISV, "CISV");
        csr_read(`IPIC_ADDR_ISVR, "ISVR");
        csr_read(`IPIC_ADDR_IPR, "IPR");
        check_value("irq_m_req_o", 32'(ref_req()), 32'(irq_req));
        set_line(3, 1'b1);
        set_line(3, 1'b0);
        wait_req(1'b1);
        csr_write(`IPIC_ADDR_SOI, 32'd0);                       // Nested start
        csr_read(`IPIC_ADDR_CISV, "CISV");
        csr_read(`IPIC_ADDR_ISVR, "ISVR");
        csr_write(`IPIC_ADDR_EOI, 32'd0);
        csr_read(`IPIC_ADDR_CISV, "CISV");
        csr_write(`IPIC_ADDR_EOI, 32'd0);
        csr_read(`IPIC_ADDR_CISV, "CISV");
        csr_read(`IPIC_ADDR_ISVR, "ISVR");
        check_value("irq_m_req_o", 32'(ref_req()), 32'(irq_req));
        csr_write(`IPIC_ADDR_IPR, 32'h400);
        wait_req(1'b0);
        csr_read(`IPIC_ADDR_IPR, "IPR");

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== ipic.f ====
+incdir+src
src/ipic_pkg.sv
src/ipic_line_detect.sv
src/ipic_csr_port.sv
src/ipic_line_regs.sv
src/ipic_prio_enc.sv
src/ipic_service_ctrl.sv
src/ipic_top.sv
bench/ipic_sva.sv
bench/ipic_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ipic_tb \
    -f ipic.f \
    -o ipic_sim

./obj_dir/ipic_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== src/ipic_config.svh ====
//------------------------------
// Sized for exactly 16 lines because the priority tree is fixed to that width
// Read data is 32 bits and only the low bits of each register are used
//------------------------------
`ifndef IPIC_CONFIG_SVH
`define IPIC_CONFIG_SVH

// Line and vector widths
`define IPIC_LINES_NUM      16
`define IPIC_IDX_W          4
`define IPIC_VECT_W         5          // MSB set only for the void vector
`define IPIC_VOID_VECT      5'd16      // CISV value with nothing in service
`define IPIC_XLEN           32

// Register map ------------------
`define IPIC_ADDR_CISV      3'd0
`define IPIC_ADDR_CICSR     3'd1       // Reserved, reads zero
`define IPIC_ADDR_IPR       3'd2
`define IPIC_ADDR_ISVR      3'd3
`define IPIC_ADDR_EOI       3'd4
`define IPIC_ADDR_SOI       3'd5
`define IPIC_ADDR_IDX       3'd6
`define IPIC_ADDR_ICSR      3'd7

// ICSR layout -------------------
`define IPIC_ICSR_IP        0
`define IPIC_ICSR_IE        1
`define IPIC_ICSR_IM        2          // 0 level, 1 edge
`define IPIC_ICSR_INV       3
`define IPIC_ICSR_IS        4
`define IPIC_ICSR_PRV_LSB   8          // Two bits wide
`define IPIC_PRV_M          2'd3       // Machine mode only
`define IPIC_ICSR_LN_LSB    16         // Four bit line number

`endif

// ==== src/ipic_csr_port.sv ====
//------------------------------
// Reads are combinational and zero without a read strobe
// Writes act on the next edge. Reserved and strobe addresses read zero
//------------------------------
`include "ipic_config.svh"

module ipic_csr_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ipic_pkg::ipic_csr_req_t     csr_req_i,
    input  ipic_pkg::ipic_line_cfg_t    cfg_i,
    input  ipic_pkg::ipic_vec_t         isvr_i,
    input  logic [`IPIC_VECT_W-1:0]     cisv_i,
    output ipic_pkg::ipic_wr_sel_t      wr_sel_o,
    output logic [`IPIC_IDX_W-1:0]      idx_o,
    output logic [`IPIC_XLEN-1:0]       rdata_o
);

    logic [`IPIC_IDX_W-1:0] idx_q;      // Line selected for ICSR

    // Write decode ------------------
    always_comb begin
        wr_sel_o = '0;
        if (csr_req_i.wr) begin
            case (csr_req_i.addr)
                `IPIC_ADDR_IPR  : wr_sel_o.ipr  = 1'b1;
                `IPIC_ADDR_EOI  : wr_sel_o.eoi  = 1'b1;
                `IPIC_ADDR_SOI  : wr_sel_o.soi  = 1'b1;
                `IPIC_ADDR_IDX  : wr_sel_o.idx  = 1'b1;
                `IPIC_ADDR_ICSR : wr_sel_o.icsr = 1'b1;
                default         : wr_sel_o      = '0;   // CISV, ISVR read only
            endcase
        end
    end

    // IDX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (wr_sel_o.idx) begin
            idx_q <= csr_req_i.wdata[`IPIC_IDX_W-1:0];  // Upper bits dropped
        end
    end

    assign idx_o = idx_q;

    // Read mux ----------------------
    always_comb begin
        rdata_o = '0;
        if (csr_req_i.rd) begin
            case (csr_req_i.addr)
                `IPIC_ADDR_CISV : rdata_o = `IPIC_XLEN'(cisv_i);
                `IPIC_ADDR_IPR  : rdata_o = `IPIC_XLEN'(cfg_i.ipr);
                `IPIC_ADDR_ISVR : rdata_o = `IPIC_XLEN'(isvr_i);
                `IPIC_ADDR_IDX  : rdata_o = `IPIC_XLEN'(idx_q);
                `IPIC_ADDR_ICSR : begin
                    // View of line IDX
                    rdata_o[`IPIC_ICSR_IP]  = cfg_i.ipr[idx_q];
                    rdata_o[`IPIC_ICSR_IE]  = cfg_i.ier[idx_q];
                    rdata_o[`IPIC_ICSR_IM]  = cfg_i.imr[idx_q];
                    rdata_o[`IPIC_ICSR_INV] = cfg_i.iinvr[idx_q];
                    rdata_o[`IPIC_ICSR_IS]  = isvr_i[idx_q];
                    rdata_o[`IPIC_ICSR_PRV_LSB +: 2]          = `IPIC_PRV_M;
                    rdata_o[`IPIC_ICSR_LN_LSB +: `IPIC_IDX_W] = idx_q;
                end
                default         : rdata_o = '0;     // CICSR, EOI, SOI
            endcase
        end
    end

endmodule

// ==== src/ipic_line_detect.sv ====
//------------------------------
// Two stage synchronizer is always on. Level and edge outputs lag the pins by two cycles
//------------------------------
module ipic_line_detect (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::ipic_vec_t irq_lines_i,    // Raw async lines
    input  ipic_pkg::ipic_vec_t iinvr_i,        // Per line inversion
    output ipic_pkg::ipic_vec_t lvl_o,          // Active level
    output ipic_pkg::ipic_vec_t edge_o          // Change into active level
);
    import ipic_pkg::*;

    ipic_vec_t sync_q1;     // First sync stage
    ipic_vec_t sync_q2;     // Synchronized lines
    ipic_vec_t prev_q;      // Synced lines one cycle back

    // Synchronizer and history --------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= irq_lines_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // Inverted lines are active low
    assign lvl_o = sync_q2 ^ iinvr_i;

    // Any toggle that ends up in the active level
    assign edge_o = (sync_q2 ^ prev_q) & lvl_o;

endmodule

// ==== src/ipic_line_regs.sv ====
//------------------------------
// IPR clears are refused while a level mode line is still active
//------------------------------
`include "ipic_config.svh"

module ipic_line_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ipic_pkg::ipic_wr_sel_t      wr_sel_i,
    input  logic [`IPIC_XLEN-1:0]       wdata_i,
    input  logic [`IPIC_IDX_W-1:0]      idx_i,
    input  ipic_pkg::ipic_vec_t         lvl_i,
    input  ipic_pkg::ipic_vec_t         edge_i,
    input  ipic_pkg::ipic_prio_t        start_i,    // Accepted SOI
    output ipic_pkg::ipic_line_cfg_t    cfg_o
);
    import ipic_pkg::*;

    ipic_vec_t ier_q;
    ipic_vec_t imr_q;
    ipic_vec_t iinvr_q;
    ipic_vec_t ipr_q;
    ipic_vec_t ipr_clr_req;     // Clear asked by software or start
    ipic_vec_t ipr_clr;         // Clear that is allowed
    ipic_vec_t ipr_next;

    // Line config -------------------
    // Only the line under IDX is touched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ier_q   <= '0;
            imr_q   <= '0;
            iinvr_q <= '0;
        end else if (wr_sel_i.icsr) begin
            ier_q[idx_i]   <= wdata_i[`IPIC_ICSR_IE];
            imr_q[idx_i]   <= wdata_i[`IPIC_ICSR_IM];
            iinvr_q[idx_i] <= wdata_i[`IPIC_ICSR_INV];
        end
    end

    // Pending clear sources ---------
    always_comb begin
        ipr_clr_req = '0;
        if (wr_sel_i.ipr) begin
            ipr_clr_req = wdata_i[`IPIC_LINES_NUM-1:0];     // Write 1 to clear
        end
        if (wr_sel_i.icsr) begin
            ipr_clr_req[idx_i] = ipr_clr_req[idx_i] | wdata_i[`IPIC_ICSR_IP];
        end
        if (start_i.vd) begin
            ipr_clr_req[start_i.idx] = 1'b1;                // Started line
        end
    end

    // Edge mode, or level gone inactive
    assign ipr_clr = ipr_clr_req & (~lvl_i | imr_q);

    // Next pending per line
    always_comb begin
        for (int i = 0; i < `IPIC_LINES_NUM; i++) begin
            if (ipr_clr[i]) begin
                ipr_next[i] = 1'b0;
            end else if (imr_q[i]) begin
                ipr_next[i] = ipr_q[i] | edge_i[i];     // Edge latches
            end else begin
                ipr_next[i] = lvl_i[i];                 // Level follows
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ipr_q <= '0;
        end else begin
            ipr_q <= ipr_next;
        end
    end

    assign cfg_o.ier   = ier_q;
    assign cfg_o.imr   = imr_q;
    assign cfg_o.iinvr = iinvr_q;
    assign cfg_o.ipr   = ipr_q;

endmodule

// ==== src/ipic_pkg.sv ====
//------------------------------
// Shared types of the interrupt controller
//------------------------------
`include "ipic_config.svh"

package ipic_pkg;

    // One bit per IRQ line
    typedef logic [`IPIC_LINES_NUM-1:0] ipic_vec_t;

    // Register access from the CSR unit
    // Single cycle strobes, never both set
    typedef struct packed {
        logic                   rd;     // Read strobe
        logic                   wr;     // Write strobe
        logic [2:0]             addr;   // Register address
        logic [`IPIC_XLEN-1:0]  wdata;  // Write data
    } ipic_csr_req_t;

    // Decoded write strobes
    typedef struct packed {
        logic ipr;                      // IPR clear write
        logic eoi;                      // End of interrupt
        logic soi;                      // Start of interrupt
        logic idx;                      // Index register
        logic icsr;                     // Per line control
    } ipic_wr_sel_t;

    // Priority search result or start pulse
    typedef struct packed {
        logic                   vd;     // Any bit found / start accepted
        logic [`IPIC_IDX_W-1:0] idx;    // Line index
    } ipic_prio_t;

    // Line configuration and pending state
    typedef struct packed {
        ipic_vec_t ier;                 // Enable
        ipic_vec_t imr;                 // Mode, 1 = edge
        ipic_vec_t iinvr;               // Inversion
        ipic_vec_t ipr;                 // Pending
    } ipic_line_cfg_t;

endpackage

// ==== src/ipic_prio_enc.sv ====
//------------------------------
// Fixed four level tree for 16 inputs. Index is 15 when nothing is set
//------------------------------
module ipic_prio_enc (
    input  ipic_pkg::ipic_vec_t     vec_i,
    output ipic_pkg::ipic_prio_t    prio_o
);

    logic [7:0] vd_s1;
    logic       idx_s1 [8];
    logic [3:0] vd_s2;
    logic [1:0] idx_s2 [4];
    logic [1:0] vd_s3;
    logic [2:0] idx_s3 [2];

    always_comb begin
        // Pairs of input bits
        for (int i = 0; i < 8; i++) begin
            vd_s1[i]  = vec_i[2*i] | vec_i[2*i+1];
            idx_s1[i] = ~vec_i[2*i];                    // Low bit wins
        end
        // Pairs of pairs
        for (int i = 0; i < 4; i++) begin
            vd_s2[i]  = vd_s1[2*i] | vd_s1[2*i+1];
            idx_s2[i] = vd_s1[2*i] ? {1'b0, idx_s1[2*i]} : {1'b1, idx_s1[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            vd_s3[i]  = vd_s2[2*i] | vd_s2[2*i+1];
            idx_s3[i] = vd_s2[2*i] ? {1'b0, idx_s2[2*i]} : {1'b1, idx_s2[2*i+1]};
        end
        // Root
        prio_o.vd  = vd_s3[0] | vd_s3[1];
        prio_o.idx = vd_s3[0] ? {1'b0, idx_s3[0]} : {1'b1, idx_s3[1]};
    end

endmodule

// ==== src/ipic_service_ctrl.sv ====
//------------------------------
// Lower index means higher priority. SOI is ignored while the request is low
//------------------------------
`include "ipic_config.svh"

module ipic_service_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ipic_pkg::ipic_wr_sel_t      wr_sel_i,
    input  ipic_pkg::ipic_line_cfg_t    cfg_i,
    output ipic_pkg::ipic_prio_t        start_o,
    output ipic_pkg::ipic_vec_t         isvr_o,
    output logic [`IPIC_VECT_W-1:0]     cisv_o,
    output logic                        irq_m_req_o
);
    import ipic_pkg::*;

    logic [`IPIC_VECT_W-1:0]    cisv_q;     // Current vector in service
    ipic_vec_t                  isvr_q;     // All lines in service
    ipic_vec_t                  req_v;      // Pending and enabled
    ipic_vec_t                  isvr_eoi;   // ISVR minus current line
    ipic_prio_t                 req_prio;
    ipic_prio_t                 eoi_prio;
    logic                       serv_vd;
    logic [`IPIC_IDX_W-1:0]     serv_idx;
    logic                       start_vd;
    logic                       eoi_vd;

    // Void vector has the MSB set
    assign serv_vd  = ~cisv_q[`IPIC_VECT_W-1];
    assign serv_idx = cisv_q[`IPIC_IDX_W-1:0];

    assign req_v = cfg_i.ipr & cfg_i.ier;

    always_comb begin
        isvr_eoi = isvr_q;
        if (serv_vd) begin
            isvr_eoi[serv_idx] = 1'b0;
        end
    end

    // Priority searches -------------
    ipic_prio_enc u_req_enc (
        .vec_i  (req_v),
        .prio_o (req_prio)
    );

    ipic_prio_enc u_eoi_enc (
        .vec_i  (isvr_eoi),
        .prio_o (eoi_prio)
    );

    // Preempt only a lower priority line
    assign irq_m_req_o = req_prio.vd & (~serv_vd | (req_prio.idx < serv_idx));

    assign start_vd = wr_sel_i.soi & irq_m_req_o;
    assign eoi_vd   = wr_sel_i.eoi & serv_vd;     // EOI with nothing in service is dropped

    assign start_o.vd  = start_vd;
    assign start_o.idx = req_prio.idx;

    // Service state -----------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cisv_q <= `IPIC_VOID_VECT;
            isvr_q <= '0;
        end else if (start_vd) begin
            cisv_q               <= {1'b0, req_prio.idx};   // Nest on top
            isvr_q[req_prio.idx] <= 1'b1;
        end else if (eoi_vd) begin
            // Fall back to the best line still in service
            cisv_q <= eoi_prio.vd ? {1'b0, eoi_prio.idx} : `IPIC_VOID_VECT;
            isvr_q <= isvr_eoi;
        end
    end

    assign isvr_o = isvr_q;
    assign cisv_o = cisv_q;

endmodule

// ==== src/ipic_top.sv ====
//------------------------------
// One register access per cycle with no acknowledge
//------------------------------
`include "ipic_config.svh"

module ipic_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ipic_pkg::ipic_vec_t         irq_lines_i,    // Async IRQ pins
    input  ipic_pkg::ipic_csr_req_t     csr_req_i,      // From CSR unit
    output logic [`IPIC_XLEN-1:0]       rdata_o,        // Same cycle read data
    output logic                        irq_m_req_o     // To CPU
);
    import ipic_pkg::*;

    ipic_vec_t                  irq_lvl;
    ipic_vec_t                  irq_edge;
    ipic_vec_t                  isvr;
    ipic_line_cfg_t             cfg;
    ipic_wr_sel_t               wr_sel;
    ipic_prio_t                 start;
    logic [`IPIC_IDX_W-1:0]     idx;
    logic [`IPIC_VECT_W-1:0]    cisv;

    // Pin side ----------------------
    ipic_line_detect u_line_detect (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .iinvr_i     (cfg.iinvr),
        .lvl_o       (irq_lvl),
        .edge_o      (irq_edge)
    );

    // Register port -----------------
    ipic_csr_port u_csr_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_req_i (csr_req_i),
        .cfg_i     (cfg),
        .isvr_i    (isvr),
        .cisv_i    (cisv),
        .wr_sel_o  (wr_sel),
        .idx_o     (idx),
        .rdata_o   (rdata_o)
    );

    ipic_line_regs u_line_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_sel_i (wr_sel),
        .wdata_i  (csr_req_i.wdata),
        .idx_i    (idx),
        .lvl_i    (irq_lvl),
        .edge_i   (irq_edge),
        .start_i  (start),
        .cfg_o    (cfg)
    );

    // Priority and service
    ipic_service_ctrl u_service_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sel_i    (wr_sel),
        .cfg_i       (cfg),
        .start_o     (start),
        .isvr_o      (isvr),
        .cisv_o      (cisv),
        .irq_m_req_o (irq_m_req_o)
    );

endmodule
